/* sources.f */
logic/xor_mem_pkg.sv
logic/delay_line.sv
logic/init_sweep.sv
logic/port_stage.sv
logic/bank_ram.sv
logic/forward_unit.sv
logic/xor_combine.sv
logic/xor_mem_top.sv
test/xor_mem_checker.sv
test/xor_mem_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= xor_mem_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=

.PHONY: sim clean

# Pass or fail is taken from the log, not from the simulator exit code.
sim:
	$(VERILATOR) --binary --timing -Mdir $(BUILD_DIR) --top-module $(TOP) \
		-f $(FILELIST) $(VFLAGS)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Result: PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/xor_mem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module xor_mem_tb;

  localparam int          NUM_OPS        = 400;
  localparam logic [31:0] SEED           = 32'hb4e9;
  localparam int          RST_CYCLES     = 4;
  // Small address window so collisions and forwarding are frequent.
  localparam int          WINDOW_BASE    = 16;
  localparam int          WINDOW_SIZE    = 8;
  localparam int          DIRECTED_OPS   = 6;
  localparam int          TIMEOUT_CYCLES = RST_CYCLES + xor_mem_pkg::NUM_ADDR + 2 +
                                           NUM_OPS + 20;

  logic                   clk;
  logic                   rst;
  logic                   ready;
  xor_mem_pkg::port_req_t req [xor_mem_pkg::NUM_PORTS];
  xor_mem_pkg::port_rsp_t rsp [xor_mem_pkg::NUM_PORTS];
  logic [31:0]            lcg_state;
  int                     cycle_cnt = 0;
  int                     errors;
  int                     checked;
  int                     pending;

  xor_mem_top UUT (
    .clk   (clk),
    .rst   (rst),
    .req   (req),
    .rsp   (rsp),
    .ready (ready)
  );

  xor_mem_checker u_checker (
    .clk     (clk),
    .rst     (rst),
    .ready   (ready),
    .req     (req),
    .rsp     (rsp),
    .errors  (errors),
    .checked (checked),
    .pending (pending)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ####################################################################
  // Stimulus helpers.
  // ####################################################################

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Idle, read, or write (writes twice as likely).
  task automatic random_command(output xor_mem_pkg::port_req_t cmd);
    logic [1:0] op;
    lcg_state = lcg_next(lcg_state);
    op        = lcg_state[31:30];
    cmd.read  = (op == 2'd1);
    cmd.write = op[1];
    cmd.addr  = xor_mem_pkg::addr_t'(WINDOW_BASE + int'(lcg_state[29:27]));
    lcg_state = lcg_next(lcg_state);
    cmd.din   = lcg_state;
  endtask

  task automatic drive_random();
    xor_mem_pkg::port_req_t cmd;
    for (int p = 0; p < xor_mem_pkg::NUM_PORTS; p++) begin
      random_command(cmd);
      req[p] <= cmd;
    end
  endtask

  task automatic set_command(input int p, input logic rd, input logic wr,
                             input xor_mem_pkg::addr_t a, input xor_mem_pkg::data_t d);
    req[p] <= '{read: rd, write: wr, addr: a, din: d};
  endtask

  task automatic clear_commands();
    for (int p = 0; p < xor_mem_pkg::NUM_PORTS; p++) begin
      req[p] <= '0;
    end
  endtask

  // ####################################################################
  // Main sequence.
  // ####################################################################

  initial begin
    rst       = 1'b1;
    lcg_state = SEED;
    for (int p = 0; p < xor_mem_pkg::NUM_PORTS; p++) begin
      req[p] = '0;
    end
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;

    // Traffic during the sweep must be dropped.
    do begin
      @(posedge clk);
      drive_random();
    end while (ready !== 1'b1);

    // Never-written words read back as zero.
    for (int i = 0; i < WINDOW_SIZE; i += 2) begin
      @(posedge clk);
      set_command(0, 1'b1, 1'b0, xor_mem_pkg::addr_t'(WINDOW_BASE + WINDOW_SIZE + i), '0);
      set_command(1, 1'b1, 1'b0, xor_mem_pkg::addr_t'(WINDOW_BASE + WINDOW_SIZE + i + 1),
                  '0);
    end

    // Same-address write on both ports, then read it back.
    @(posedge clk);
    set_command(0, 1'b0, 1'b1, xor_mem_pkg::addr_t'(WINDOW_BASE + 3), 32'h1111_0000);
    set_command(1, 1'b0, 1'b1, xor_mem_pkg::addr_t'(WINDOW_BASE + 3), 32'h2222_ffff);
    @(posedge clk);
    set_command(0, 1'b1, 1'b0, xor_mem_pkg::addr_t'(WINDOW_BASE + 3), '0);
    set_command(1, 1'b1, 1'b0, xor_mem_pkg::addr_t'(WINDOW_BASE + 3), '0);

    for (int n = DIRECTED_OPS; n < NUM_OPS; n++) begin
      @(posedge clk);
      drive_random();
    end

    @(posedge clk);
    clear_commands();
    repeat (xor_mem_pkg::SRAM_DELAY + 2) @(posedge clk);
    @(negedge clk);

    if (pending != 0) begin
      $display("Read responses were still outstanding when the run ended.");
    end
    $display("Errors: %0d, reads checked: %0d, responses outstanding: %0d",
             errors, checked, pending);
    if (errors == 0 && pending == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the run did not complete.", cycle_cnt);
      $display("Result: FAILED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* test/xor_mem_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module xor_mem_checker (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire logic                   ready,
  input  wire xor_mem_pkg::port_req_t req [xor_mem_pkg::NUM_PORTS],
  input  wire xor_mem_pkg::port_rsp_t rsp [xor_mem_pkg::NUM_PORTS],
  output int                          errors,
  output int                          checked,
  output int                          pending
);

  typedef struct packed {
    int                 due;
    xor_mem_pkg::addr_t addr;
    xor_mem_pkg::data_t data;
  } expect_t;

  xor_mem_pkg::data_t shadow [xor_mem_pkg::NUM_ADDR];
  expect_t            exp_q  [xor_mem_pkg::NUM_PORTS][$];
  int                 edges_done;
  logic               exp_ready;

  task automatic check_response(input int p);
    expect_t ent;
    if (rsp[p].vld !== 1'b0) begin
      if (exp_q[p].size() == 0 || exp_q[p][0].due != edges_done) begin
        errors++;
        $display("Port %0d gave a read response with no read pending, cycle %0d.",
                 p, edges_done);
      end else begin
        ent = exp_q[p].pop_front();
        checked++;
        if (rsp[p].dout !== ent.data) begin
          errors++;
          $display("[FAIL] rsp[%0d].dout addr 0x%h: got 0x%h, expected 0x%h",
                   p, ent.addr, rsp[p].dout, ent.data);
        end
      end
    end else if (exp_q[p].size() != 0 && exp_q[p][0].due == edges_done) begin
      ent = exp_q[p].pop_front();
      errors++;
      $display("Port %0d read of address 0x%h got no response in time.", p, ent.addr);
    end
  endtask

  // Sampled at the edge, so all values are the settled pre-edge ones.
  always @(posedge clk) begin
    if (rst) begin
      errors     = 0;
      checked    = 0;
      pending    = 0;
      edges_done = 0;
      for (int a = 0; a < xor_mem_pkg::NUM_ADDR; a++) begin
        shadow[a] = '0;
      end
      for (int p = 0; p < xor_mem_pkg::NUM_PORTS; p++) begin
        exp_q[p].delete();
      end
    end else begin
      // Sweep takes NUM_ADDR+1 edges.
      exp_ready = (edges_done >= xor_mem_pkg::NUM_ADDR + 1);
      if (ready !== exp_ready) begin
        errors++;
        $display("[FAIL] ready: got 0x%h, expected 0x%h", ready, exp_ready);
      end
      for (int p = 0; p < xor_mem_pkg::NUM_PORTS; p++) begin
        check_response(p);
      end
      // Reads see memory before this cycle's writes.
      for (int p = 0; p < xor_mem_pkg::NUM_PORTS; p++) begin
        if (exp_ready && req[p].read) begin
          exp_q[p].push_back(expect_t'{due:  edges_done + xor_mem_pkg::SRAM_DELAY,
                                       addr: req[p].addr,
                                       data: shadow[req[p].addr]});
        end
      end
      // Higher port applied last, so it wins.
      for (int p = 0; p < xor_mem_pkg::NUM_PORTS; p++) begin
        if (exp_ready && req[p].write) begin
          shadow[req[p].addr] = req[p].din;
        end
      end
      pending = 0;
      for (int p = 0; p < xor_mem_pkg::NUM_PORTS; p++) begin
        pending += exp_q[p].size();
      end
      edges_done++;
    end
  end

endmodule

`default_nettype wire

/* logic/xor_mem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module xor_mem_top (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire xor_mem_pkg::port_req_t req [xor_mem_pkg::NUM_PORTS],
  output xor_mem_pkg::port_rsp_t      rsp [xor_mem_pkg::NUM_PORTS],
  output logic                        ready
);

  xor_mem_pkg::bank_wr_t    init_wr;
  xor_mem_pkg::bank_rd_t    bank_rd  [xor_mem_pkg::NUM_BANKS];
  xor_mem_pkg::bank_wr_t    bank_wr  [xor_mem_pkg::NUM_BANKS];
  xor_mem_pkg::data_t       rd_data  [xor_mem_pkg::NUM_BANKS];
  xor_mem_pkg::data_t       fwd_data [xor_mem_pkg::NUM_BANKS];
  xor_mem_pkg::req_stages_t stages;
  xor_mem_pkg::port_req_t   tail_req [xor_mem_pkg::NUM_PORTS];

  // ####################################################################
  // Control.
  // ####################################################################

  init_sweep u_init_sweep (
    .clk     (clk),
    .rst     (rst),
    .ready   (ready),
    .init_wr (init_wr)
  );

  port_stage u_port_stage (
    .clk      (clk),
    .rst      (rst),
    .ready    (ready),
    .req      (req),
    .bank_rd  (bank_rd),
    .stages   (stages),
    .tail_req (tail_req)
  );

  // Unaccepted commands only capture into stages nobody consumes.
  forward_unit u_forward_unit (
    .clk      (clk),
    .rst      (rst),
    .stages   (stages),
    .issue    (req),
    .bank_wr  (bank_wr),
    .rd_data  (rd_data),
    .fwd_data (fwd_data),
    .hit      ()
  );

  xor_combine u_xor_combine (
    .init_wr  (init_wr),
    .tail_req (tail_req),
    .fwd_data (fwd_data),
    .rsp      (rsp),
    .bank_wr  (bank_wr)
  );

  // ####################################################################
  // Banks.
  // ####################################################################

  for (genvar b = 0; b < xor_mem_pkg::NUM_BANKS; b++) begin : g_bank
    bank_ram u_bank (
      .clk     (clk),
      .wr      (bank_wr[b]),
      .rd      (bank_rd[b]),
      .rd_data (rd_data[b])
    );
  end

endmodule

`default_nettype wire

/* logic/xor_combine.sv */
`timescale 1ns/1ps
`default_nettype none

module xor_combine (
  input  wire xor_mem_pkg::bank_wr_t  init_wr,
  input  wire xor_mem_pkg::port_req_t tail_req [xor_mem_pkg::NUM_PORTS],
  input  wire xor_mem_pkg::data_t     fwd_data [xor_mem_pkg::NUM_BANKS],
  output xor_mem_pkg::port_rsp_t      rsp      [xor_mem_pkg::NUM_PORTS],
  output xor_mem_pkg::bank_wr_t       bank_wr  [xor_mem_pkg::NUM_BANKS]
);

  xor_mem_pkg::data_t row_xor [xor_mem_pkg::NUM_PORTS];
  xor_mem_pkg::data_t col_din [xor_mem_pkg::NUM_PORTS];

  // ####################################################################
  // Read side.
  // ####################################################################

  // Each row XORs back to the stored word.
  always_comb begin
    for (int r = 0; r < xor_mem_pkg::NUM_PORTS; r++) begin
      row_xor[r] = '0;
      for (int c = 0; c < xor_mem_pkg::NUM_PORTS; c++) begin
        row_xor[r] = row_xor[r] ^ fwd_data[r*xor_mem_pkg::NUM_PORTS + c];
      end
      rsp[r].vld  = tail_req[r].read;
      rsp[r].dout = row_xor[r];
    end
  end

  // ####################################################################
  // Write side.
  // ####################################################################

  // Cancel the own column out of the row, then fold in the new data.
  always_comb begin
    for (int c = 0; c < xor_mem_pkg::NUM_PORTS; c++) begin
      col_din[c] = tail_req[c].din ^ row_xor[c] ^
                   fwd_data[c*xor_mem_pkg::NUM_PORTS + c];
    end
  end

  // Sweep writes hit every bank.
  always_comb begin
    for (int r = 0; r < xor_mem_pkg::NUM_PORTS; r++) begin
      for (int c = 0; c < xor_mem_pkg::NUM_PORTS; c++) begin
        if (init_wr.write) begin
          bank_wr[r*xor_mem_pkg::NUM_PORTS + c] = init_wr;
        end else begin
          bank_wr[r*xor_mem_pkg::NUM_PORTS + c].write = tail_req[c].write;
          bank_wr[r*xor_mem_pkg::NUM_PORTS + c].addr  = tail_req[c].addr;
          bank_wr[r*xor_mem_pkg::NUM_PORTS + c].din   = col_din[c];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* logic/forward_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module forward_unit (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire xor_mem_pkg::req_stages_t stages,
  input  wire xor_mem_pkg::port_req_t issue    [xor_mem_pkg::NUM_PORTS],
  input  wire xor_mem_pkg::bank_wr_t  bank_wr  [xor_mem_pkg::NUM_BANKS],
  input  wire xor_mem_pkg::data_t     rd_data  [xor_mem_pkg::NUM_BANKS],
  output xor_mem_pkg::data_t          fwd_data [xor_mem_pkg::NUM_BANKS],
  output logic                        hit      [xor_mem_pkg::NUM_BANKS]
);

  for (genvar r = 0; r < xor_mem_pkg::NUM_PORTS; r++) begin : g_row
    for (genvar c = 0; c < xor_mem_pkg::NUM_PORTS; c++) begin : g_col
      localparam int B = r * xor_mem_pkg::NUM_PORTS + c;

      logic               look_act  [xor_mem_pkg::SRAM_DELAY];
      xor_mem_pkg::addr_t look_addr [xor_mem_pkg::SRAM_DELAY];
      logic               match     [xor_mem_pkg::SRAM_DELAY];
      logic               cap_vld   [xor_mem_pkg::SRAM_DELAY];
      xor_mem_pkg::data_t cap_data  [xor_mem_pkg::SRAM_DELAY];

      // Stage s looks at the command that moves into it next edge.
      always_comb begin
        look_act[0]  = issue[r].read || issue[r].write;
        look_addr[0] = issue[r].addr;
        for (int s = 1; s < xor_mem_pkg::SRAM_DELAY; s++) begin
          look_act[s]  = stages[s-1][r].read || stages[s-1][r].write;
          look_addr[s] = stages[s-1][r].addr;
        end
        for (int s = 0; s < xor_mem_pkg::SRAM_DELAY; s++) begin
          match[s] = bank_wr[B].write && look_act[s] && bank_wr[B].addr == look_addr[s];
        end
      end

      always_ff @(posedge clk) begin
        if (rst) begin
          for (int s = 0; s < xor_mem_pkg::SRAM_DELAY; s++) begin
            cap_vld[s] <= 1'b0;
          end
        end else begin
          cap_vld[0] <= match[0];
          for (int s = 1; s < xor_mem_pkg::SRAM_DELAY; s++) begin
            cap_vld[s] <= match[s] || cap_vld[s-1];
          end
        end
      end

      // Newest write beats whatever shifted in.
      always_ff @(posedge clk) begin
        cap_data[0] <= bank_wr[B].din;
        for (int s = 1; s < xor_mem_pkg::SRAM_DELAY; s++) begin
          cap_data[s] <= match[s] ? bank_wr[B].din : cap_data[s-1];
        end
      end

      assign hit[B]      = cap_vld[xor_mem_pkg::SRAM_DELAY-1];
      assign fwd_data[B] = hit[B] ? cap_data[xor_mem_pkg::SRAM_DELAY-1] : rd_data[B];
    end
  end

endmodule

`default_nettype wire

/* logic/bank_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module bank_ram (
  input  wire logic                  clk,
  input  wire xor_mem_pkg::bank_wr_t wr,
  input  wire xor_mem_pkg::bank_rd_t rd,
  output xor_mem_pkg::data_t         rd_data
);

  xor_mem_pkg::data_t mem     [xor_mem_pkg::NUM_ADDR];
  xor_mem_pkg::data_t rd_pipe [xor_mem_pkg::SRAM_DELAY];

  always_ff @(posedge clk) begin
    if (wr.write) begin
      mem[wr.addr] <= wr.din;
    end
  end

  // Same-edge write is not visible here, old word comes out.
  always_ff @(posedge clk) begin
    if (rd.read) begin
      rd_pipe[0] <= mem[rd.addr];
    end
    for (int i = 1; i < xor_mem_pkg::SRAM_DELAY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign rd_data = rd_pipe[xor_mem_pkg::SRAM_DELAY-1];

endmodule

`default_nettype wire

/* logic/port_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module port_stage (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire logic                    ready,
  input  wire xor_mem_pkg::port_req_t  req      [xor_mem_pkg::NUM_PORTS],
  output xor_mem_pkg::bank_rd_t        bank_rd  [xor_mem_pkg::NUM_BANKS],
  output xor_mem_pkg::req_stages_t     stages,
  output xor_mem_pkg::port_req_t       tail_req [xor_mem_pkg::NUM_PORTS]
);

  xor_mem_pkg::port_req_t gated [xor_mem_pkg::NUM_PORTS];
  xor_mem_pkg::port_req_t taps  [xor_mem_pkg::NUM_PORTS][xor_mem_pkg::SRAM_DELAY];

  // Commands only count once the sweep is done.
  always_comb begin
    for (int p = 0; p < xor_mem_pkg::NUM_PORTS; p++) begin
      gated[p] = ready ? req[p] : '0;
    end
  end

  // Port r reads its whole row, writes included.
  always_comb begin
    for (int r = 0; r < xor_mem_pkg::NUM_PORTS; r++) begin
      for (int c = 0; c < xor_mem_pkg::NUM_PORTS; c++) begin
        bank_rd[r*xor_mem_pkg::NUM_PORTS + c].read = gated[r].read || gated[r].write;
        bank_rd[r*xor_mem_pkg::NUM_PORTS + c].addr = gated[r].addr;
      end
    end
  end

  for (genvar p = 0; p < xor_mem_pkg::NUM_PORTS; p++) begin : g_port
    delay_line #(
      .payload_t (xor_mem_pkg::port_req_t),
      .DEPTH     (xor_mem_pkg::SRAM_DELAY)
    ) u_req_pipe (
      .clk  (clk),
      .rst  (rst),
      .din  (gated[p]),
      .taps (taps[p])
    );
  end

  always_comb begin
    for (int s = 0; s < xor_mem_pkg::SRAM_DELAY; s++) begin
      for (int p = 0; p < xor_mem_pkg::NUM_PORTS; p++) begin
        stages[s][p] = taps[p][s];
      end
    end
  end

  // ####################################################################
  // Same-address writes at the tail: the higher port wins.
  // ####################################################################

  always_comb begin
    for (int p = 0; p < xor_mem_pkg::NUM_PORTS; p++) begin
      tail_req[p] = stages[xor_mem_pkg::SRAM_DELAY-1][p];
      for (int q = p + 1; q < xor_mem_pkg::NUM_PORTS; q++) begin
        if (stages[xor_mem_pkg::SRAM_DELAY-1][q].write &&
            stages[xor_mem_pkg::SRAM_DELAY-1][q].addr == tail_req[p].addr) begin
          tail_req[p].write = 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* logic/init_sweep.sv */
`timescale 1ns/1ps
`default_nettype none

module init_sweep (
  input  wire logic             clk,
  input  wire logic             rst,
  output logic                  ready,
  output xor_mem_pkg::bank_wr_t init_wr
);

  logic [xor_mem_pkg::ADDR_BITS:0] sweep_cnt;
  logic                            sweep_busy;
  xor_mem_pkg::bank_wr_t           sweep_wr;
  xor_mem_pkg::bank_wr_t           sweep_taps [xor_mem_pkg::SRAM_DELAY];

  // NUM_ADDR is a power of two, so the top bit marks the end.
  assign sweep_busy = !sweep_cnt[xor_mem_pkg::ADDR_BITS];

  always_ff @(posedge clk) begin
    if (rst) begin
      sweep_cnt <= '0;
      ready     <= 1'b0;
    end else begin
      if (sweep_busy) begin
        sweep_cnt <= sweep_cnt + 1'b1;
      end
      ready <= !sweep_busy;
    end
  end

  assign sweep_wr = '{write: sweep_busy,
                      addr:  sweep_cnt[xor_mem_pkg::ADDR_BITS-1:0],
                      din:   '0};

  // Align the zero writes with the tail of the request pipeline.
  delay_line #(
    .payload_t (xor_mem_pkg::bank_wr_t),
    .DEPTH     (xor_mem_pkg::SRAM_DELAY)
  ) u_init_pipe (
    .clk  (clk),
    .rst  (rst),
    .din  (sweep_wr),
    .taps (sweep_taps)
  );

  assign init_wr = sweep_taps[xor_mem_pkg::SRAM_DELAY-1];

endmodule

`default_nettype wire

/* logic/delay_line.sv */
`timescale 1ns/1ps
`default_nettype none

module delay_line #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 2
) (
  input  wire logic clk,
  input  wire logic rst,
  input  wire payload_t din,
  output payload_t  taps [DEPTH]
);

  // Stage 0 holds the value from one cycle back.
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        taps[i] <= '0;
      end
    end else begin
      taps[0] <= din;
      for (int i = 1; i < DEPTH; i++) begin
        taps[i] <= taps[i-1];
      end
    end
  end

endmodule

`default_nettype wire

/* logic/xor_mem_pkg.sv */
`default_nettype none

package xor_mem_pkg;

  // ####################################################################
  // Sizes.
  // ####################################################################

  localparam int WIDTH      = 32;
  localparam int NUM_PORTS  = 2;
  // Bank (r,c) sits at index r*NUM_PORTS+c.
  localparam int NUM_BANKS  = NUM_PORTS * NUM_PORTS;
  localparam int NUM_ADDR   = 64;
  localparam int ADDR_BITS  = $clog2(NUM_ADDR);
  // Bank read latency, also the request pipeline depth.
  localparam int SRAM_DELAY = 2;

  // ####################################################################
  // Types.
  // ####################################################################

  typedef logic [ADDR_BITS-1:0] addr_t;
  typedef logic [WIDTH-1:0]     data_t;

  typedef struct packed {
    logic  read;
    logic  write;
    addr_t addr;
    data_t din;
  } port_req_t;

  typedef struct packed {
    logic  vld;
    data_t dout;
  } port_rsp_t;

  typedef struct packed {
    logic  write;
    addr_t addr;
    data_t din;
  } bank_wr_t;

  typedef struct packed {
    logic  read;
    addr_t addr;
  } bank_rd_t;

  // Stage index first, then port.
  typedef port_req_t req_stages_t [SRAM_DELAY][NUM_PORTS];

endpackage

`default_nettype wire
